// File: common/tile_consts.svh
// Bus widths, memory sizes and region tags of the tile fabric

`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

//////////////////////////////
// Bus widths

`define TILE_AW          32     // Address width
`define TILE_DW          32     // Data width
`define TILE_TAG_W       4      // Region tag in the top address bits
`define TILE_OFS_W       28     // Offset inside a region

//////////////////////////////
// Memory sizes

`define TILE_DMEM_WORDS  1024   // Local data memory depth
`define TILE_DMEM_IDX_W  10     // Word index into local memory
`define TILE_ROM_WORDS   16     // Boot ROM depth

//////////////////////////////
// Region tags

`define TAG_DMEM         4'h0   // Local data memory
`define TAG_EXT          4'h8   // External memory port
`define TAG_ROM          4'hF   // Boot ROM

`endif

// File: common/bootrom_image.svh
// Boot ROM contents, sixteen 32-bit words listed from word index 0

`ifndef BOOTROM_IMAGE_SVH
`define BOOTROM_IMAGE_SVH

`define BOOTROM_IMAGE '{ \
  32'h4031_0400, \
  32'h40B2_5A80, \
  32'h0120_4303, \
  32'h4035_0000, \
  32'h4036_0400, \
  32'h4387_0000, \
  32'h5327_9605, \
  32'h23FC_4303, \
  32'h4034_8000, \
  32'h4415_0000, \
  32'h4584_0000, \
  32'h5324_5325, \
  32'h9034_8040, \
  32'h23F9_4303, \
  32'h4030_8000, \
  32'h3FFF_4303 \
}

`endif

// File: common/tile_pkg.sv
// Shared bus types: two-view address word and slave select

`default_nettype none

package tile_pkg;

`include "tile_consts.svh"

  typedef struct packed {
    logic [`TILE_TAG_W-1:0] tag;  // Region tag
    logic [`TILE_OFS_W-1:0] ofs;  // Byte offset in region
  } tile_addr_s;

  // Same bits read flat by masters, split by decoder and memories
  typedef union packed {
    logic [`TILE_AW-1:0] word;
    tile_addr_s          fld;
  } tile_addr_u;

  typedef enum logic [1:0] {
    SEL_DMEM,
    SEL_ROM,
    SEL_EXT,
    SEL_NONE                      // Unmapped tag or no read
  } slave_sel_e;

endpackage

`default_nettype wire

// File: common/bb_if.sv
// Single-cycle memory-style bus with master and slave modports

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"

interface bb_if import tile_pkg::*; ();

  tile_addr_u          addr;
  logic [`TILE_DW-1:0] din;
  logic                en;
  logic                we;
  logic [`TILE_DW-1:0] dout;     // Read data, one cycle after en

  modport master (
    output addr, din, en, we,
    input  dout
  );

  modport slave (
    input  addr, din, en, we,
    output dout
  );

endinterface

`default_nettype wire

// File: bus/bb_arbiter.sv
// Round-robin arbiter for two bus masters, with read-data return steering

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"

module bb_arbiter import tile_pkg::*; (
  input  wire                 clk,
  input  wire                 rst_n_i,

  input  tile_addr_u          m0_addr_i,
  input  wire  [`TILE_DW-1:0] m0_din_i,
  input  wire                 m0_en_i,
  input  wire                 m0_we_i,
  output logic                m0_gnt_o,
  output logic [`TILE_DW-1:0] m0_dout_o,

  input  tile_addr_u          m1_addr_i,
  input  wire  [`TILE_DW-1:0] m1_din_i,
  input  wire                 m1_en_i,
  input  wire                 m1_we_i,
  output logic                m1_gnt_o,
  output logic [`TILE_DW-1:0] m1_dout_o,

  bb_if.master                bus
);

  logic last_m1_q;    // Master 1 held the bus last
  logic rd_pend_q;    // Read data returns this cycle
  logic rd_own_q;     // Owner of that read, 1 = master 1

  //////////////////////////////
  // Grant

  // A lone requester always wins, a tie goes to the one not served last
  assign m0_gnt_o = m0_en_i & (~m1_en_i | last_m1_q);
  assign m1_gnt_o = m1_en_i & (~m0_en_i | ~last_m1_q);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_m1_q <= 1'b1;                  // Master 0 first after reset
    end else if (m0_gnt_o) begin
      last_m1_q <= 1'b0;
    end else if (m1_gnt_o) begin
      last_m1_q <= 1'b1;
    end
  end

  //////////////////////////////
  // Forward the granted transfer

  assign bus.en   = m0_gnt_o | m1_gnt_o;
  assign bus.addr = m1_gnt_o ? m1_addr_i : m0_addr_i;
  assign bus.din  = m1_gnt_o ? m1_din_i  : m0_din_i;
  assign bus.we   = m1_gnt_o ? m1_we_i   : m0_we_i;

  //////////////////////////////
  // Read return

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_pend_q <= 1'b0;
      rd_own_q  <= 1'b0;
    end else begin
      rd_pend_q <= bus.en & ~bus.we;
      rd_own_q  <= m1_gnt_o;
    end
  end

  assign m0_dout_o = (rd_pend_q && !rd_own_q) ? bus.dout : '0;
  assign m1_dout_o = (rd_pend_q &&  rd_own_q) ? bus.dout : '0;

endmodule

`default_nettype wire

// File: bus/bb_decoder.sv
// Region decoder onto local memory, boot ROM and external bus
// Read data mux with zero answer for unmapped regions

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"

module bb_decoder import tile_pkg::*; (
  input  wire  clk,
  input  wire  rst_n_i,

  bb_if.slave  up,
  bb_if.master dmem,
  bb_if.master rom,
  bb_if.master ext
);

  slave_sel_e sel;      // Target of the current transfer
  slave_sel_e sel_q;    // Target of the read returning now

  //////////////////////////////
  // Region decode

  always_comb begin
    case (up.addr.fld.tag)
      `TAG_DMEM: sel = SEL_DMEM;
      `TAG_ROM:  sel = SEL_ROM;
      `TAG_EXT:  sel = SEL_EXT;
      default:   sel = SEL_NONE;
    endcase
  end

  // Request lines fan out, only one enable goes high
  assign dmem.addr = up.addr;
  assign dmem.din  = up.din;
  assign dmem.we   = up.we;
  assign dmem.en   = up.en & (sel == SEL_DMEM);

  assign rom.addr  = up.addr;
  assign rom.din   = up.din;
  assign rom.we    = up.we;
  assign rom.en    = up.en & (sel == SEL_ROM);    // ROM drops writes itself

  assign ext.addr  = up.addr;
  assign ext.din   = up.din;
  assign ext.we    = up.we;
  assign ext.en    = up.en & (sel == SEL_EXT);

  //////////////////////////////
  // Read data return

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sel_q <= SEL_NONE;
    end else if (up.en && !up.we) begin
      sel_q <= sel;
    end else begin
      sel_q <= SEL_NONE;                          // Nothing to return
    end
  end

  always_comb begin
    case (sel_q)
      SEL_DMEM: up.dout = dmem.dout;
      SEL_ROM:  up.dout = rom.dout;
      SEL_EXT:  up.dout = ext.dout;
      default:  up.dout = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/bb_sram.sv
// Local data memory, single port, registered read

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"

module bb_sram (
  input wire  clk,
  input wire  rst_n_i,

  bb_if.slave bus
);

  logic [`TILE_DW-1:0]         mem [`TILE_DMEM_WORDS];
  logic [`TILE_DMEM_IDX_W-1:0] idx;
  logic [`TILE_DW-1:0]         dout_q;

  // Word index above the byte bits
  assign idx = bus.addr.fld.ofs[`TILE_DMEM_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (bus.en && bus.we) begin
      mem[idx] <= bus.din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dout_q <= '0;
    end else if (bus.en && !bus.we) begin
      dout_q <= mem[idx];                 // Valid one cycle after en
    end
  end

  assign bus.dout = dout_q;

endmodule

`default_nettype wire

// File: verilog/bb_bootrom.sv
// Boot ROM from the image table, registered read, writes ignored

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"
`include "bootrom_image.svh"

module bb_bootrom (
  input wire  clk,
  input wire  rst_n_i,

  bb_if.slave bus
);

  localparam int ROM_IDX_W = $clog2(`TILE_ROM_WORDS);

  localparam logic [`TILE_DW-1:0] IMAGE [`TILE_ROM_WORDS] = `BOOTROM_IMAGE;

  logic [ROM_IDX_W-1:0] idx;
  logic [`TILE_DW-1:0]  dout_q;

  // Low offset bits only, image repeats across the region
  assign idx = bus.addr.fld.ofs[ROM_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dout_q <= '0;
    end else if (bus.en && !bus.we) begin
      dout_q <= IMAGE[idx];
    end
  end

  assign bus.dout = dout_q;

endmodule

`default_nettype wire

// File: verilog/msp430_tile_top.sv
// Tile bus fabric top: two master ports, arbiter, decoder,
// local memory, boot ROM and external memory port

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"

module msp430_tile_top (
  input  wire                 clk,
  input  wire                 rst_n_i,

  // Program port master
  input  wire  [`TILE_AW-1:0] m0_addr_i,
  input  wire  [`TILE_DW-1:0] m0_din_i,
  input  wire                 m0_en_i,
  input  wire                 m0_we_i,
  output wire                 m0_gnt_o,
  output wire  [`TILE_DW-1:0] m0_dout_o,

  // Data port master
  input  wire  [`TILE_AW-1:0] m1_addr_i,
  input  wire  [`TILE_DW-1:0] m1_din_i,
  input  wire                 m1_en_i,
  input  wire                 m1_we_i,
  output wire                 m1_gnt_o,
  output wire  [`TILE_DW-1:0] m1_dout_o,

  // External memory
  output wire  [`TILE_AW-1:0] ext_addr_o,
  output wire  [`TILE_DW-1:0] ext_din_o,
  output wire                 ext_en_o,
  output wire                 ext_we_o,
  input  wire  [`TILE_DW-1:0] ext_dout_i
);

  bb_if bus_up   ();    // Arbiter to decoder
  bb_if bus_dmem ();
  bb_if bus_rom  ();
  bb_if bus_ext  ();

  //////////////////////////////
  // Bus fabric

  bb_arbiter u_arbiter (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .m0_addr_i (m0_addr_i),
    .m0_din_i  (m0_din_i),
    .m0_en_i   (m0_en_i),
    .m0_we_i   (m0_we_i),
    .m0_gnt_o  (m0_gnt_o),
    .m0_dout_o (m0_dout_o),
    .m1_addr_i (m1_addr_i),
    .m1_din_i  (m1_din_i),
    .m1_en_i   (m1_en_i),
    .m1_we_i   (m1_we_i),
    .m1_gnt_o  (m1_gnt_o),
    .m1_dout_o (m1_dout_o),
    .bus       (bus_up)
  );

  bb_decoder u_decoder (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .up      (bus_up),
    .dmem    (bus_dmem),
    .rom     (bus_rom),
    .ext     (bus_ext)
  );

  //////////////////////////////
  // Slaves

  bb_sram u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (bus_dmem)
  );

  bb_bootrom u_bootrom (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (bus_rom)
  );

  // External region leaves the tile as plain pins
  assign ext_addr_o   = bus_ext.addr.word;
  assign ext_din_o    = bus_ext.din;
  assign ext_en_o     = bus_ext.en;
  assign ext_we_o     = bus_ext.we;
  assign bus_ext.dout = ext_dout_i;   // Sampled in the cycle after en

endmodule

`default_nettype wire

// File: verif/tb_msp430_tile.sv
// Tile bus fabric testbench with clock, reset, stimulus,
// external memory model, reference model and assertions

`timescale 1ns/1ns
`default_nettype none

`include "tile_consts.svh"
`include "bootrom_image.svh"

module tb_msp430_tile import tile_pkg::*; ();

  localparam int TIMEOUT   = 20;                  // Cycles a master may wait for a grant
  localparam int ROM_IDX_W = $clog2(`TILE_ROM_WORDS);
  localparam logic [`TILE_DW-1:0] ROM_REF [`TILE_ROM_WORDS] = `BOOTROM_IMAGE;

  logic                clk = 1'b0;
  logic                rst_n_i = 1'b0;
  logic [`TILE_AW-1:0] m0_addr_i = '0;
  logic [`TILE_DW-1:0] m0_din_i = '0;
  logic                m0_en_i = 1'b0;
  logic                m0_we_i = 1'b0;
  logic [`TILE_AW-1:0] m1_addr_i = '0;
  logic [`TILE_DW-1:0] m1_din_i = '0;
  logic                m1_en_i = 1'b0;
  logic                m1_we_i = 1'b0;
  logic [`TILE_DW-1:0] ext_dout_i = '0;
  wire                 m0_gnt_o;
  wire                 m1_gnt_o;
  wire  [`TILE_DW-1:0] m0_dout_o;
  wire  [`TILE_DW-1:0] m1_dout_o;
  wire  [`TILE_AW-1:0] ext_addr_o;
  wire  [`TILE_DW-1:0] ext_din_o;
  wire                 ext_en_o;
  wire                 ext_we_o;

  logic [31:0] seed = 32'he06f0800;
  string       test_name = "reset";
  int          err_cnt = 0;
  int          xfer_cnt = 0;

  logic [`TILE_DW-1:0] ext_mem  [logic [`TILE_AW-1:0]];          // External memory contents
  logic [`TILE_DW-1:0] ext_ref  [logic [`TILE_AW-1:0]];          // Expected external contents
  logic [`TILE_DW-1:0] dmem_ref [logic [`TILE_DMEM_IDX_W-1:0]];
  logic [`TILE_AW-1:0] dmem_addrs [$];

  always #4 clk = ~clk;

  msp430_tile_top u_msp430_tile_top (.*);

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] rand_addr(input logic [`TILE_TAG_W-1:0] tag);
    logic [31:0] r;
    r = rand32();
    return {tag, r[`TILE_OFS_W-1:0]};
  endfunction

  function automatic logic [31:0] ext_fill(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'hA5C3_3C5A;    // Unwritten external words
  endfunction

  function automatic slave_sel_e region_of(input logic [31:0] a);
    tile_addr_u u;
    u.word = a;
    case (u.fld.tag)
      `TAG_DMEM: return SEL_DMEM;
      `TAG_ROM:  return SEL_ROM;
      `TAG_EXT:  return SEL_EXT;
      default:   return SEL_NONE;
    endcase
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    logic [`TILE_DMEM_IDX_W-1:0] idx;
    idx = a[`TILE_DMEM_IDX_W+1:2];
    case (region_of(a))
      SEL_DMEM: return dmem_ref.exists(idx) ? dmem_ref[idx] : 32'h0;
      SEL_ROM:  return ROM_REF[a[ROM_IDX_W+1:2]];
      SEL_EXT:  return ext_ref.exists(a) ? ext_ref[a] : ext_fill(a);
      default:  return 32'h0;
    endcase
  endfunction

  //////////////////////////////
  // Reference model

  logic        last_m1_m;
  logic        exp_gnt0;
  logic        exp_gnt1;
  logic        exp_ext_en;
  logic [31:0] g_addr;
  logic [31:0] g_din;
  logic        g_we;
  logic [31:0] exp_dout0;
  logic [31:0] exp_dout1;
  slave_sel_e  exp_sel0_q;
  slave_sel_e  exp_sel1_q;
  int          wait0;
  int          wait1;

  always_comb begin
    exp_gnt0   = m0_en_i && (!m1_en_i || last_m1_m);   // Tie goes to the one not served last
    exp_gnt1   = m1_en_i && !exp_gnt0;
    g_addr     = exp_gnt1 ? m1_addr_i : m0_addr_i;
    g_din      = exp_gnt1 ? m1_din_i : m0_din_i;
    g_we       = exp_gnt1 ? m1_we_i : m0_we_i;
    exp_ext_en = (exp_gnt0 || exp_gnt1) && region_of(g_addr) == SEL_EXT;
  end

  always @(posedge clk) begin
    if (!rst_n_i) begin
      last_m1_m  <= 1'b1;
      exp_dout0  <= '0;
      exp_dout1  <= '0;
      exp_sel0_q <= SEL_NONE;
      exp_sel1_q <= SEL_NONE;
      wait0      <= 0;
      wait1      <= 0;
    end else begin
      wait0      <= (m0_en_i && !m0_gnt_o) ? wait0 + 1 : 0;
      wait1      <= (m1_en_i && !m1_gnt_o) ? wait1 + 1 : 0;
      exp_dout0  <= '0;                               // Non-owner reads zero
      exp_dout1  <= '0;
      exp_sel0_q <= SEL_NONE;
      exp_sel1_q <= SEL_NONE;
      if (exp_gnt0 || exp_gnt1) begin
        xfer_cnt++;
        last_m1_m <= exp_gnt1;
        if (g_we && region_of(g_addr) == SEL_DMEM) begin
          dmem_ref[g_addr[`TILE_DMEM_IDX_W+1:2]] = g_din;
        end else if (g_we && region_of(g_addr) == SEL_EXT) begin
          ext_ref[g_addr] = g_din;
        end else if (!g_we && exp_gnt0) begin
          exp_dout0  <= ref_read(g_addr);
          exp_sel0_q <= region_of(g_addr);
        end else if (!g_we) begin
          exp_dout1  <= ref_read(g_addr);
          exp_sel1_q <= region_of(g_addr);
        end
      end
    end
  end

  // External memory answers reads one cycle later
  always @(posedge clk) begin : ext_memory_model
    logic        rd;
    logic [31:0] a;
    rd = ext_en_o && !ext_we_o;
    a  = ext_addr_o;
    if (ext_en_o && ext_we_o) begin
      ext_mem[a] = ext_din_o;
    end
    #1;
    ext_dout_i = !rd ? 32'hDEAD_BEEF : (ext_mem.exists(a) ? ext_mem[a] : ext_fill(a));
  end

  //////////////////////////////
  // Assertions

  a_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
      m0_gnt_o == exp_gnt0 && m1_gnt_o == exp_gnt1)
    else begin
      err_cnt++;
      $display("[ERROR] %s: grants expected %b%b, actual %b%b", test_name,
               $sampled(exp_gnt1), $sampled(exp_gnt0), $sampled(m1_gnt_o), $sampled(m0_gnt_o));
    end

  a_ext_en: assert property (@(posedge clk) disable iff (!rst_n_i) ext_en_o == exp_ext_en)
    else begin
      err_cnt++;
      $display("[ERROR] %s: ext_en_o expected %b, actual %b", test_name,
               $sampled(exp_ext_en), $sampled(ext_en_o));
    end

  a_ext_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      !exp_ext_en || (ext_addr_o == g_addr && ext_din_o == g_din && ext_we_o == g_we))
    else begin
      err_cnt++;
      $display("[ERROR] %s: ext request expected %h/%h/%b, actual %h/%h/%b", test_name,
               $sampled(g_addr), $sampled(g_din), $sampled(g_we),
               $sampled(ext_addr_o), $sampled(ext_din_o), $sampled(ext_we_o));
    end

  a_dout0: assert property (@(posedge clk) disable iff (!rst_n_i) m0_dout_o == exp_dout0)
    else begin
      slave_sel_e s;
      s = $sampled(exp_sel0_q);
      err_cnt++;
      $display("[ERROR] %s: m0 read from %s expected %h, actual %h", test_name, s.name(),
               $sampled(exp_dout0), $sampled(m0_dout_o));
    end

  a_dout1: assert property (@(posedge clk) disable iff (!rst_n_i) m1_dout_o == exp_dout1)
    else begin
      slave_sel_e s;
      s = $sampled(exp_sel1_q);
      err_cnt++;
      $display("[ERROR] %s: m1 read from %s expected %h, actual %h", test_name, s.name(),
               $sampled(exp_dout1), $sampled(m1_dout_o));
    end

  a_wait: assert property (@(posedge clk) disable iff (!rst_n_i) wait0 < 2 && wait1 < 2)
    else begin
      err_cnt++;
      $display("%s: a master waited more than one cycle for its grant", test_name);
    end

  //////////////////////////////
  // Stimulus

  task automatic drive_req(input bit m, input bit en, input bit we,
                           input logic [31:0] addr, input logic [31:0] data);
    if (m) begin
      m1_en_i   = en;
      m1_we_i   = we;
      m1_addr_i = addr;
      m1_din_i  = data;
    end else begin
      m0_en_i   = en;
      m0_we_i   = we;
      m0_addr_i = addr;
      m0_din_i  = data;
    end
  endtask

  // Request, hold until granted, release after the grant cycle
  task automatic xfer(input bit m, input bit we, input logic [31:0] addr,
                      input logic [31:0] data);
    int cnt;
    cnt = 0;
    drive_req(m, 1'b1, we, addr, data);
    @(negedge clk);
    while (!(m ? m1_gnt_o : m0_gnt_o) && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk);
    end
    if (!(m ? m1_gnt_o : m0_gnt_o)) begin
      $display("Timeout in %s: master %0d was never granted", test_name, m);
      $display("Test FAILED");
      $finish;
    end else begin
      @(posedge clk);
      #1;
      drive_req(m, 1'b0, 1'b0, '0, '0);
    end
  endtask

  task automatic read_burst(input bit m, input logic [`TILE_TAG_W-1:0] tag, input int n);
    for (int k = 0; k < n; k++) begin
      xfer(m, 1'b0, rand_addr(tag), '0);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  initial begin : stimulus
    logic [31:0]             a;
    logic [`TILE_TAG_W-1:0]  t;
    idle(5);
    rst_n_i = 1'b1;
    test_name = "reset_idle";
    idle(4);

    test_name = "dmem_rw";
    for (int i = 0; i < 12; i++) begin
      a = rand_addr(`TAG_DMEM);
      dmem_addrs.push_back(a);
      xfer(i[0], 1'b1, a, rand32());
    end
    for (int i = 0; i < 12; i++) begin
      xfer(!i[0], 1'b0, dmem_addrs[i], '0);          // Read back through the other master
    end

    test_name = "rom";
    for (int i = 0; i < 8; i++) begin
      a = rand_addr(`TAG_ROM);
      xfer(i[0], 1'b0, a, '0);
      xfer(!i[0], 1'b1, a, rand32());                 // Dropped by the ROM
      xfer(i[0], 1'b0, a, '0);
    end

    test_name = "ext";
    for (int i = 0; i < 6; i++) begin
      a = rand_addr(`TAG_EXT);
      xfer(i[0], 1'b1, a, rand32());
      xfer(!i[0], 1'b0, a, '0);
      xfer(i[0], 1'b0, rand_addr(`TAG_EXT), '0);      // Unwritten word
    end

    test_name = "unmapped";
    for (int i = 0; i < 6; i++) begin
      do begin
        a = rand32();
        t = a[`TILE_AW-1:`TILE_OFS_W];
      end while (t == `TAG_DMEM || t == `TAG_EXT || t == `TAG_ROM);
      a = {t, dmem_addrs[i][`TILE_OFS_W-1:0]};
      xfer(i[0], 1'b1, a, rand32());
      xfer(!i[0], 1'b0, a, '0);
      xfer(i[0], 1'b0, dmem_addrs[i], '0);            // Same offset in local memory
      xfer(!i[0], 1'b0, {`TAG_EXT, a[`TILE_OFS_W-1:0]}, '0);
    end

    test_name = "contention";
    fork
      read_burst(1'b0, `TAG_ROM, 12);
      read_burst(1'b1, `TAG_EXT, 12);
    join
    idle(4);

    $display("Transfers: %0d, errors: %0d", xfer_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: msp430_tile.f
+incdir+common
common/tile_pkg.sv
common/bb_if.sv
bus/bb_arbiter.sv
bus/bb_decoder.sv
verilog/bb_sram.sv
verilog/bb_bootrom.sv
verilog/msp430_tile_top.sv
verif/tb_msp430_tile.sv

// File: run_sim.sh
#!/bin/sh
# Compile the tile fabric testbench with Verilator, run it, check the log

verilator --binary --timing --assert -f msp430_tile.f --top-module tb_msp430_tile \
  -o sim_tile > build.log 2>&1 \
  && ./obj_dir/sim_tile > sim.log 2>&1

grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
